/* compile.f */
source/eeprom_bus_pkg.sv
source/i2c_phy_pkg.sv
source/eeprom_request_latch.sv
source/eeprom_transfer_sequencer.sv
source/i2c_bit_engine.sv
source/eeprom_ctrl_top.sv
test/eeprom_slave_model.sv
test/eeprom_ctrl_tb.sv

/* source/eeprom_bus_pkg.sv */
package eeprom_bus_pkg;

    // 2 KB part, eight blocks of 256 bytes
    typedef logic [10:0] word_addr_t;

    // top three address bits, sent inside the control byte
    typedef logic [2:0] block_sel_t;

    typedef logic [7:0] data_byte_t;

    // fixed upper nibble of every control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

endpackage

/* source/eeprom_ctrl_top.sv */
`timescale 1ns/1ps

module eeprom_ctrl_top
    import eeprom_bus_pkg::*, i2c_phy_pkg::*;
#(
    parameter int SCL_HALF_PERIOD = 4  // clk cycles per half scl period, 2 or more
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       wr,
    input  logic       rd,
    input  word_addr_t addr,
    input  data_byte_t wr_data,
    output data_byte_t rd_data,
    output logic       ack,
    output logic       nack_err,
    output logic       busy,
    output logic       scl,
    inout  wire        sda
);

    logic       req_start;
    logic       req_read;
    word_addr_t req_addr;
    data_byte_t req_data;
    logic       cmd_valid;
    bus_cmd_t   cmd;
    data_byte_t tx_byte;
    logic       cmd_done;
    logic       rx_nack;
    data_byte_t rx_byte;

    eeprom_request_latch u_latch (
        .CLK       (CLK),
        .RESET     (RESET),
        .wr        (wr),
        .rd        (rd),
        .addr      (addr),
        .wr_data   (wr_data),
        .ack       (ack),
        .busy      (busy),
        .req_start (req_start),
        .req_read  (req_read),
        .req_addr  (req_addr),
        .req_data  (req_data)
    );

    eeprom_transfer_sequencer u_seq (
        .CLK       (CLK),
        .RESET     (RESET),
        .req_start (req_start),
        .req_read  (req_read),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .cmd_done  (cmd_done),
        .rx_nack   (rx_nack),
        .rx_byte   (rx_byte),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .ack       (ack),
        .nack_err  (nack_err),
        .rd_data   (rd_data)
    );

    i2c_bit_engine #(
        .SCL_HALF_PERIOD (SCL_HALF_PERIOD)
    ) u_phy (
        .CLK       (CLK),
        .RESET     (RESET),
        .cmd_valid (cmd_valid),
        .cmd       (cmd),
        .tx_byte   (tx_byte),
        .cmd_done  (cmd_done),
        .rx_nack   (rx_nack),
        .rx_byte   (rx_byte),
        .scl       (scl),
        .sda       (sda)
    );

endmodule

/* source/eeprom_request_latch.sv */
`timescale 1ns/1ps

module eeprom_request_latch
    import eeprom_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       wr,
    input  logic       rd,
    input  word_addr_t addr,
    input  data_byte_t wr_data,
    input  logic       ack,
    output logic       busy,
    output logic       req_start,
    output logic       req_read,
    output word_addr_t req_addr,
    output data_byte_t req_data
);

    logic accept;

    assign accept = (wr || rd) && !busy;  // strobes while busy are dropped

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            req_start <= 1'b0;
            req_read  <= 1'b0;
        end
        else
        begin
            req_start <= accept;
            if (accept)
            begin
                busy     <= 1'b1;
                req_read <= rd;
            end
            else if (ack)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_addr <= addr;
            req_data <= wr_data;
        end
    end

    a_single_strobe: assert property (@(posedge CLK) disable iff (RESET) !(wr && rd));

    // sequencer only finishes a request this block handed over
    a_ack_while_busy: assert property (@(posedge CLK) disable iff (RESET) ack |-> busy);

endmodule

/* source/eeprom_transfer_sequencer.sv */
`timescale 1ns/1ps

module eeprom_transfer_sequencer
    import eeprom_bus_pkg::*, i2c_phy_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       req_start,
    input  logic       req_read,
    input  word_addr_t req_addr,
    input  data_byte_t req_data,
    input  logic       cmd_done,
    input  logic       rx_nack,
    input  data_byte_t rx_byte,
    output logic       cmd_valid,
    output bus_cmd_t   cmd,
    output data_byte_t tx_byte,
    output logic       ack,
    output logic       nack_err,
    output data_byte_t rd_data
);

    typedef enum logic [3:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_CTRL_WR,
        SEQ_ADDR,
        SEQ_DATA,
        SEQ_RESTART,
        SEQ_CTRL_RD,
        SEQ_READ,
        SEQ_STOP
    } seq_state_t;

    seq_state_t state;
    logic       wr_byte_done;

    // device code, block select, r/w bit
    function automatic data_byte_t ctrl_byte(input block_sel_t blk, input logic rd_bit);
        ctrl_byte = {DEVICE_CODE, blk, rd_bit};
    endfunction

    task automatic issue(input bus_cmd_t c, input data_byte_t b);
        cmd_valid <= 1'b1;
        cmd       <= c;
        tx_byte   <= b;
    endtask

    // rx_nack only means something after a byte we sent
    assign wr_byte_done = cmd_done &&
                          (state inside {SEQ_CTRL_WR, SEQ_ADDR, SEQ_DATA, SEQ_CTRL_RD});

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state     <= SEQ_IDLE;
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
            nack_err  <= 1'b0;
        end
        else
        begin
            cmd_valid <= 1'b0;
            ack       <= 1'b0;
            if (wr_byte_done && rx_nack)
            begin
                nack_err <= 1'b1;  // no ack from slave, stop right away
                issue(CMD_STOP, 8'h00);
                state <= SEQ_STOP;
            end
            else
            begin
                case (state)
                    SEQ_IDLE:
                        if (req_start)
                        begin
                            nack_err <= 1'b0;
                            issue(CMD_START, 8'h00);
                            state <= SEQ_START;
                        end
                    SEQ_START:
                        if (cmd_done)
                        begin
                            issue(CMD_WRITE_BYTE, ctrl_byte(req_addr[10:8], 1'b0));
                            state <= SEQ_CTRL_WR;
                        end
                    SEQ_CTRL_WR:
                        if (cmd_done)
                        begin
                            issue(CMD_WRITE_BYTE, req_addr[7:0]);
                            state <= SEQ_ADDR;
                        end
                    SEQ_ADDR:
                        if (cmd_done && req_read)
                        begin
                            issue(CMD_START, 8'h00);  // repeated start
                            state <= SEQ_RESTART;
                        end
                        else if (cmd_done)
                        begin
                            issue(CMD_WRITE_BYTE, req_data);
                            state <= SEQ_DATA;
                        end
                    SEQ_DATA, SEQ_READ:
                        if (cmd_done)
                        begin
                            issue(CMD_STOP, 8'h00);
                            state <= SEQ_STOP;
                        end
                    SEQ_RESTART:
                        if (cmd_done)
                        begin
                            issue(CMD_WRITE_BYTE, ctrl_byte(req_addr[10:8], 1'b1));
                            state <= SEQ_CTRL_RD;
                        end
                    SEQ_CTRL_RD:
                        if (cmd_done)
                        begin
                            issue(CMD_READ_BYTE, 8'h00);
                            state <= SEQ_READ;
                        end
                    SEQ_STOP:
                        if (cmd_done)
                        begin
                            ack   <= 1'b1;
                            state <= SEQ_IDLE;
                        end
                    default:
                        state <= SEQ_IDLE;
                endcase
            end
        end
    end

    // held until the next read finishes
    always_ff @(posedge CLK)
    begin
        if (state == SEQ_READ && cmd_done)
            rd_data <= rx_byte;
    end

    a_one_cmd_in_flight: assert property (@(posedge CLK) disable iff (RESET)
        cmd_valid |=> (!cmd_valid throughout cmd_done[->1]));

endmodule

/* source/i2c_bit_engine.sv */
`timescale 1ns/1ps

module i2c_bit_engine
    import eeprom_bus_pkg::*, i2c_phy_pkg::*;
#(
    parameter int SCL_HALF_PERIOD = 4
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       cmd_valid,
    input  bus_cmd_t   cmd,
    input  data_byte_t tx_byte,
    output logic       cmd_done,
    output logic       rx_nack,
    output data_byte_t rx_byte,
    output logic       scl,
    inout  wire        sda
);

    localparam int CNT_W = $clog2(SCL_HALF_PERIOD);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(SCL_HALF_PERIOD - 1);
    localparam logic [CNT_W-1:0] MID  = CNT_W'(SCL_HALF_PERIOD / 2);

    phy_state_t       state;
    logic [CNT_W-1:0] cnt;       // position inside the half period
    logic             phase_end;
    logic [2:0]       bit_cnt;
    logic             is_read;
    logic             in_xfer;   // between start and stop
    data_byte_t       tx_sr;
    logic             sda_low;
    logic             scl_next;
    logic             sda_low_next;

    assign phase_end = (cnt == LAST);
    assign sda       = sda_low ? 1'b0 : 1'bz;  // only ever pull low

    assign cmd_done = phase_end &&
                      (state == PHY_START_B || state == PHY_STOP_B || state == PHY_ACK_HIGH);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state   <= PHY_IDLE;
            cnt     <= '0;
            bit_cnt <= '0;
            in_xfer <= 1'b0;
        end
        else
        begin
            if (state == PHY_IDLE || phase_end)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;

            case (state)
                PHY_IDLE:
                    if (cmd_valid)
                    begin
                        bit_cnt <= '0;
                        case (cmd)
                            CMD_START: state <= PHY_START_A;
                            CMD_STOP:  state <= PHY_STOP_A;
                            default:   state <= PHY_BIT_LOW;
                        endcase
                    end
                PHY_START_A:
                    if (phase_end)
                        state <= PHY_START_B;
                PHY_START_B:
                    if (phase_end)
                    begin
                        in_xfer <= 1'b1;
                        state   <= PHY_IDLE;
                    end
                PHY_BIT_LOW:
                    if (phase_end)
                        state <= PHY_BIT_HIGH;
                PHY_BIT_HIGH:
                    if (phase_end)
                    begin
                        bit_cnt <= bit_cnt + 1'b1;
                        state   <= (bit_cnt == 3'd7) ? PHY_ACK_LOW : PHY_BIT_LOW;
                    end
                PHY_ACK_LOW:
                    if (phase_end)
                        state <= PHY_ACK_HIGH;
                PHY_ACK_HIGH:
                    if (phase_end)
                        state <= PHY_IDLE;
                PHY_STOP_A:
                    if (phase_end)
                        state <= PHY_STOP_B;
                PHY_STOP_B:
                    if (phase_end)
                    begin
                        in_xfer <= 1'b0;
                        state   <= PHY_IDLE;
                    end
                default:
                    state <= PHY_IDLE;
            endcase
        end
    end

    // shifters, msb first
    always_ff @(posedge CLK)
    begin
        if (state == PHY_IDLE && cmd_valid)
        begin
            tx_sr   <= tx_byte;
            is_read <= (cmd == CMD_READ_BYTE);
        end
        else if (state == PHY_BIT_HIGH && phase_end)
            tx_sr <= {tx_sr[6:0], 1'b0};

        if (state == PHY_BIT_HIGH && cnt == MID)
            rx_byte <= {rx_byte[6:0], sda};  // middle of scl high
        if (state == PHY_ACK_HIGH && cnt == MID)
            rx_nack <= sda;
    end

    // sda moves one cycle after scl falls, start/stop edges halfway through scl high
    always_comb
    begin
        scl_next     = 1'b1;
        sda_low_next = sda_low;
        case (state)
            PHY_START_A:
            begin
                scl_next = ~in_xfer;  // repeated start: drop scl before releasing sda
                if (cnt != '0)
                    sda_low_next = 1'b0;
            end
            PHY_START_B:
                sda_low_next = (cnt >= MID);
            PHY_BIT_LOW:
            begin
                scl_next = 1'b0;
                if (cnt != '0)
                    sda_low_next = ~is_read & ~tx_sr[7];
            end
            PHY_ACK_LOW:
            begin
                scl_next = 1'b0;
                if (cnt != '0)
                    sda_low_next = 1'b0;  // slave acks, or master nack after a read
            end
            PHY_STOP_A:
            begin
                scl_next = 1'b0;
                if (cnt != '0)
                    sda_low_next = 1'b1;
            end
            PHY_STOP_B:
                sda_low_next = (cnt < MID);
            default:
                sda_low_next = sda_low;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            scl     <= 1'b1;
            sda_low <= 1'b0;
        end
        else
        begin
            scl     <= scl_next;
            sda_low <= sda_low_next;
        end
    end

    a_scl_parked: assert property (@(posedge CLK) disable iff (RESET)
        state == PHY_IDLE |-> scl);

endmodule

/* source/i2c_phy_pkg.sv */
package i2c_phy_pkg;

    // byte level commands from sequencer to bit engine
    typedef enum logic [1:0] {
        CMD_START,
        CMD_STOP,
        CMD_WRITE_BYTE,
        CMD_READ_BYTE
    } bus_cmd_t;

    // each non-idle state lasts one half period of scl
    typedef enum logic [3:0] {
        PHY_IDLE,
        PHY_START_A,    // scl low for a repeated start, else bus idle
        PHY_START_B,    // scl high, sda falls halfway
        PHY_BIT_LOW,
        PHY_BIT_HIGH,
        PHY_ACK_LOW,
        PHY_ACK_HIGH,
        PHY_STOP_A,     // scl low, sda pulled low
        PHY_STOP_B      // scl high, sda released halfway
    } phy_state_t;

endpackage

/* test/eeprom_ctrl_tb.sv */
`timescale 1ns/1ps

module eeprom_ctrl_tb
    import eeprom_bus_pkg::*, i2c_phy_pkg::*;
();

    localparam int ACK_TIMEOUT = 2000;

    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    word_addr_t  addr;
    data_byte_t  wr_data;
    data_byte_t  rd_data;
    logic        ack;
    logic        nack_err;
    logic        busy;
    logic        scl;
    wire         sda;
    logic        nack_mode;

    data_byte_t  shadow [0:2047];
    logic [31:0] seed;
    string       test_name;
    logic        exp_is_read;
    logic        exp_nack;
    data_byte_t  exp_rd;
    logic        bus_open;  // between start and stop
    logic        scl_q;
    logic        sda_q;
    int          errors;
    int          issued;
    int          acked;

    eeprom_ctrl_top #(
        .SCL_HALF_PERIOD (4)
    ) dut0 (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .addr     (addr),
        .wr_data  (wr_data),
        .rd_data  (rd_data),
        .ack      (ack),
        .nack_err (nack_err),
        .busy     (busy),
        .scl      (scl),
        .sda      (sda)
    );

    eeprom_slave_model slave0 (
        .force_nack (nack_mode),
        .scl        (scl),
        .sda        (sda)
    );

    pullup (sda);

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    task automatic note_value(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        errors++;
        $display("ERROR %s: %s expected %0h, actual %0h", test_name, what, expected, actual);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("%s (during %s, at %0t ns)", what, test_name, $time);
    endtask

    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic data_byte_t fill_byte(input word_addr_t a);
        return {a[2:0], a[7:3]} ^ {5'b00000, a[10:8]} ^ 8'h5a;
    endfunction

    // start and stop seen on the lines, plus the ack count
    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda;
        if (RESET)
            bus_open <= 1'b0;
        else if (scl && scl_q && sda_q && !sda)
            bus_open <= 1'b1;
        else if (scl && scl_q && !sda_q && sda)
            bus_open <= 1'b0;
        if (ack)
            acked <= acked + 1;
    end

    a_idle_lines: assert property (@(posedge CLK) disable iff (RESET)
        !busy |-> (scl && sda === 1'b1 && !ack))
        else note_failure("bus lines or ack not idle while the controller is not busy");
    a_ack_one_cycle: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else note_failure("ack stayed high for more than one cycle");
    a_busy_rises: assert property (@(posedge CLK) disable iff (RESET)
        (wr || rd) && !busy |=> busy)
        else note_failure("busy did not rise after an accepted strobe");
    a_busy_holds: assert property (@(posedge CLK) disable iff (RESET) busy && !ack |=> busy)
        else note_failure("busy dropped before ack");
    a_busy_falls: assert property (@(posedge CLK) disable iff (RESET) ack |=> !busy)
        else note_failure("busy still high the cycle after ack");
    a_ack_per_request: assert property (@(posedge CLK) disable iff (RESET)
        ack |-> acked < issued)
        else note_failure("ack without an outstanding request");
    a_read_data: assert property (@(posedge CLK) disable iff (RESET)
        ack && exp_is_read && !exp_nack |-> rd_data == exp_rd)
        else note_value("rd_data", $sampled(exp_rd), $sampled(rd_data));
    a_nack_flag: assert property (@(posedge CLK) disable iff (RESET)
        ack |-> nack_err == exp_nack)
        else note_value("nack_err", $sampled(exp_nack), $sampled(nack_err));
    a_sda_fall: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && $fell(sda) |-> $past(dut0.u_phy.state) == PHY_START_B)
        else note_failure("sda fell while scl was high outside a start condition");
    a_sda_rise: assert property (@(posedge CLK) disable iff (RESET)
        scl && $past(scl) && $rose(sda) |-> $past(dut0.u_phy.state) == PHY_STOP_B)
        else note_failure("sda rose while scl was high outside a stop condition");
    a_ends_with_stop: assert property (@(posedge CLK) disable iff (RESET) ack |-> !bus_open)
        else note_failure("transfer finished without a stop condition");

    // called on a clock edge and returns one edge later
    task automatic request(input logic is_read, input word_addr_t a, input data_byte_t d);
        wr          <= !is_read;
        rd          <= is_read;
        addr        <= a;
        wr_data     <= d;
        exp_is_read = is_read;
        exp_nack    = nack_mode;
        exp_rd      = shadow[a];
        if (!is_read && !nack_mode)
            shadow[a] = d;
        issued++;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_for_ack();
        int cycles;
        cycles = 0;
        while (!ack && cycles < ACK_TIMEOUT)
        begin
            @(posedge CLK);
            cycles++;
        end
        if (!ack)
        begin
            $display("no ack within %0d cycles during %s", ACK_TIMEOUT, test_name);
            $display("test failed");
            $finish;
        end
    endtask

    task automatic run_transfer(input logic is_read, input word_addr_t a, input data_byte_t d);
        request(is_read, a, d);
        wait_for_ack();
    endtask

    // must be ignored by the controller
    task automatic strobe_while_busy(input word_addr_t a, input data_byte_t d);
        int cycles;
        cycles = 0;
        while (!busy && cycles < ACK_TIMEOUT)
        begin
            @(posedge CLK);
            cycles++;
        end
        if (!busy)
        begin
            $display("busy never rose during %s", test_name);
            $display("test failed");
            $finish;
        end
        wr      <= 1'b1;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
    endtask

    initial
    begin
        logic [31:0] r;
        word_addr_t  a;
        data_byte_t  d;

        RESET       = 1'b1;
        wr          = 1'b0;
        rd          = 1'b0;
        addr        = '0;
        wr_data     = '0;
        nack_mode   = 1'b0;
        seed        = 32'hf1f91aa7;
        errors      = 0;
        issued      = 0;
        acked       = 0;
        exp_is_read = 1'b0;
        exp_nack    = 1'b0;
        exp_rd      = '0;
        test_name   = "reset_idle";
        for (int i = 0; i < 2048; i++)
        begin
            shadow[i]     = fill_byte(word_addr_t'(i));
            slave0.mem[i] = shadow[i];
        end

        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        repeat (20) @(posedge CLK);  // lines stay idle without requests

        test_name = "write_read";
        a = word_addr_t'(next_random() >> 16);
        d = data_byte_t'(next_random() >> 24);
        run_transfer(1'b0, a, d);
        run_transfer(1'b1, a, 8'h00);

        test_name = "block_select";  // same low byte in every block
        for (int b = 0; b < 8; b++)
            run_transfer(1'b0, {3'(b), 8'h6c}, data_byte_t'(next_random() >> 24));
        for (int b = 0; b < 8; b++)
            run_transfer(1'b1, {3'(b), 8'h6c}, 8'h00);

        test_name = "busy_strobe";
        request(1'b0, 11'h123, 8'ha5);
        strobe_while_busy(11'h123, 8'h3c);
        wait_for_ack();
        run_transfer(1'b1, 11'h123, 8'h00);

        test_name = "nack";
        nack_mode <= 1'b1;
        @(posedge CLK);
        run_transfer(1'b0, 11'h4d2, 8'h99);
        run_transfer(1'b1, 11'h4d2, 8'h00);
        if (slave0.mem[11'h4d2] !== shadow[11'h4d2])
            note_value("slave memory", shadow[11'h4d2], slave0.mem[11'h4d2]);
        nack_mode <= 1'b0;
        @(posedge CLK);

        test_name = "random_mix";
        for (int n = 0; n < 24; n++)
        begin
            r = next_random();
            a = {r[30:28], 5'b00000, r[27:25]};  // small pool so reads hit earlier writes
            run_transfer(r[31], a, r[23:16]);
        end

        repeat (10) @(posedge CLK);
        if (acked != issued)
            note_failure("number of acks differs from the number of accepted requests");
        $display("errors: %0d, requests: %0d, acks: %0d", errors, issued, acked);
        if (errors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

/* test/eeprom_slave_model.sv */
`timescale 1ns/1ps

module eeprom_slave_model
    import eeprom_bus_pkg::*;
(
    input  logic force_nack,  // leave every byte unacknowledged
    input  logic scl,
    inout  wire  sda
);

    typedef enum logic [2:0] {
        SL_IDLE,
        SL_CTRL,
        SL_ADDR,
        SL_WDATA,
        SL_RDATA
    } slave_phase_t;

    data_byte_t   mem [0:2047];  // loaded by the testbench
    slave_phase_t phase;
    logic [3:0]   bit_cnt;
    logic         ack_slot;
    logic         drive_low;
    data_byte_t   in_sr;
    data_byte_t   out_sr;
    logic [2:0]   blk;
    data_byte_t   ptr;

    assign sda = drive_low ? 1'b0 : 1'bz;

    initial
    begin
        phase     = SL_IDLE;
        bit_cnt   = '0;
        ack_slot  = 1'b0;
        drive_low = 1'b0;
        blk       = '0;
        ptr       = '0;
    end

    // whole byte received, decide on the acknowledge
    task automatic finish_byte();
        drive_low = 1'b0;
        case (phase)
            SL_CTRL:
                if (!force_nack && in_sr[7:4] == DEVICE_CODE)
                begin
                    blk       = in_sr[3:1];
                    drive_low = 1'b1;
                    out_sr    = mem[{blk, ptr}];
                    phase     = in_sr[0] ? SL_RDATA : SL_ADDR;
                end
                else
                    phase = SL_IDLE;
            SL_ADDR:
                if (!force_nack)
                begin
                    ptr       = in_sr;
                    drive_low = 1'b1;
                    phase     = SL_WDATA;
                end
                else
                    phase = SL_IDLE;
            SL_WDATA:
            begin
                if (!force_nack)
                begin
                    mem[{blk, ptr}] = in_sr;
                    drive_low       = 1'b1;
                end
                phase = SL_IDLE;  // single byte writes only
            end
            default:
                drive_low = 1'b0;  // after a read byte the master answers
        endcase
    endtask

    always @(negedge sda)
    begin
        if (scl)
        begin
            phase    = SL_CTRL;  // start or repeated start
            bit_cnt  = '0;
            ack_slot = 1'b0;
        end
    end

    always @(posedge sda)
    begin
        if (scl)
        begin
            phase     = SL_IDLE;  // stop
            drive_low = 1'b0;
        end
    end

    always @(posedge scl)
    begin
        if (ack_slot)
        begin
            if (phase == SL_RDATA && sda)
                phase = SL_IDLE;  // master nack ends the read
        end
        else if (bit_cnt < 8)
        begin
            in_sr   = {in_sr[6:0], sda};
            bit_cnt = bit_cnt + 1'b1;
        end
    end

    always @(negedge scl)
    begin
        if (ack_slot)
        begin
            ack_slot  = 1'b0;
            bit_cnt   = '0;
            drive_low = (phase == SL_RDATA) && !out_sr[7];
        end
        else if (bit_cnt == 8)
        begin
            ack_slot = 1'b1;
            finish_byte();
        end
        else if (phase == SL_RDATA && bit_cnt != 0)
            drive_low = !out_sr[3'd7 - bit_cnt[2:0]];  // msb first
    end

endmodule
